/* hw/mem_pkg.sv */
package mem_pkg;

    // **********************************************************************
    // access size and shared vector types
    // **********************************************************************

    typedef enum logic [1:0] {
        access_byte = 2'd0,
        access_half = 2'd1,
        access_word = 2'd2
    } access_t;

    // data word on request and response channels
    typedef logic [31:0] data_t;

    // byte address as seen by the requester
    typedef logic [31:0] addr_t;

    // one strobe per byte lane, bit n covers bits 8n+7..8n
    typedef logic [3:0] byte_en_t;

    // configuration register index
    typedef logic [1:0] cfg_addr_t;

    // **********************************************************************
    // configuration register map
    // **********************************************************************

    // accessible range in words
    localparam cfg_addr_t CFG_LIMIT = 2'd0;

    // rejected accesses, any write clears
    localparam cfg_addr_t CFG_ERR_COUNT = 2'd1;

endpackage

/* hw/byte_lane_ram.sv */
`timescale 1ns/10ps

module byte_lane_ram #(
    parameter int DEPTH = 1024
) (
    input  logic                     clock,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     we,
    input  logic [7:0]               wdata,
    output logic [7:0]               rdata
);

    logic [7:0] mem [DEPTH];

    // read-first, old contents come out on a write to the same entry
    always_ff @(posedge clock) begin
        rdata <= mem[addr];
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

/* hw/store_lane_steer.sv */
`timescale 1ns/10ps

module store_lane_steer
    import mem_pkg::*;
(
    input  access_t    size,
    input  logic [1:0] addr_low,
    input  data_t      wdata,
    output data_t      lane_data,
    output byte_en_t   lane_en,
    output logic       misaligned
);

    // store data is replicated over the lanes, the strobes pick the
    // lanes that actually take it
    always_comb begin
        lane_data  = wdata;
        lane_en    = '0;
        misaligned = 1'b0;

        case (size)
            access_byte: begin
                lane_data = {4{wdata[7:0]}};
                case (addr_low)
                    2'b00:   lane_en = 4'b0001;
                    2'b01:   lane_en = 4'b0010;
                    2'b10:   lane_en = 4'b0100;
                    default: lane_en = 4'b1000;
                endcase
            end

            access_half: begin
                lane_data = {2{wdata[15:0]}};
                if (addr_low[0]) begin
                    misaligned = 1'b1;
                end else if (addr_low[1]) begin
                    lane_en = 4'b1100;
                end else begin
                    lane_en = 4'b0011;
                end
            end

            access_word: begin
                if (addr_low != 2'b00) begin
                    misaligned = 1'b1;
                end else begin
                    lane_en = 4'b1111;
                end
            end

            // undefined size code, treat as a bad access
            default: begin
                misaligned = 1'b1;
            end
        endcase
    end

endmodule

/* hw/load_extract.sv */
`timescale 1ns/10ps

module load_extract
    import mem_pkg::*;
(
    input  access_t    size,
    input  logic [1:0] addr_low,
    input  logic       is_unsigned,
    input  data_t      word,
    output data_t      rdata
);

    data_t shifted;
    logic  fill_byte;
    logic  fill_half;

    // addressed lane moved down to bit 0
    assign shifted = word >> {addr_low, 3'b000};

    // sign bits, forced low for unsigned loads
    assign fill_byte = ~is_unsigned & shifted[7];
    assign fill_half = ~is_unsigned & shifted[15];

    always_comb begin
        case (size)
            access_byte: begin
                rdata = {{24{fill_byte}}, shifted[7:0]};
            end

            access_half: begin
                rdata = {{16{fill_half}}, shifted[15:0]};
            end

            default: begin
                rdata = word;
            end
        endcase
    end

endmodule

/* hw/mem_cfg_regs.sv */
`timescale 1ns/10ps

module mem_cfg_regs
    import mem_pkg::*;
#(
    parameter int DEPTH = 1024
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   cfg_we,
    input  cfg_addr_t              cfg_addr,
    input  data_t                  cfg_wdata,
    output data_t                  cfg_rdata,
    input  logic                   err_pulse,
    output logic [$clog2(DEPTH):0] limit
);

    localparam int AW = $clog2(DEPTH);

    data_t err_count;
    logic  limit_wr;
    logic  count_clr;

    assign limit_wr  = cfg_we && (cfg_addr == CFG_LIMIT);
    assign count_clr = cfg_we && (cfg_addr == CFG_ERR_COUNT);

    // **********************************************************************
    // limit register, in words
    // **********************************************************************

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            limit <= (AW+1)'(DEPTH);
        end else if (limit_wr) begin
            limit <= cfg_wdata[AW:0];
        end
    end

    // **********************************************************************
    // rejected-access counter
    // **********************************************************************

    // a clear wins over a rejection in the same cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            err_count <= '0;
        end else if (count_clr) begin
            err_count <= '0;
        end else if (err_pulse && (err_count != '1)) begin
            err_count <= err_count + 32'd1;
        end
    end

    // readback
    always_comb begin
        case (cfg_addr)
            CFG_LIMIT:     cfg_rdata = data_t'(limit);
            CFG_ERR_COUNT: cfg_rdata = err_count;
            default:       cfg_rdata = '0;
        endcase
    end

endmodule

/* hw/data_mem_ctrl.sv */
`timescale 1ns/10ps

module data_mem_ctrl
    import mem_pkg::*;
#(
    parameter int DEPTH   = 1024,
    parameter int CREDITS = 4
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  logic                     req_unsigned,
    input  access_t                  req_size,
    input  addr_t                    req_addr,
    input  data_t                    req_wdata,
    output logic                     credit_return,
    output logic                     rsp_valid,
    output logic                     rsp_err,
    output data_t                    rsp_rdata,
    input  logic [$clog2(DEPTH):0]   limit,
    output logic                     err_pulse,
    output logic [$clog2(DEPTH)-1:0] ram_addr,
    output byte_en_t                 ram_we,
    output data_t                    ram_wdata,
    input  data_t                    ram_rdata
);

    localparam int AW = $clog2(DEPTH);
    localparam int QW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CW = $clog2(CREDITS + 1);

    // **********************************************************************
    // request queue
    // **********************************************************************

    logic    q_write    [CREDITS];
    logic    q_unsigned [CREDITS];
    access_t q_size     [CREDITS];
    addr_t   q_addr     [CREDITS];
    data_t   q_wdata    [CREDITS];

    logic [QW-1:0] wr_ptr;
    logic [QW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          issue;

    // head issues whenever the queue holds something
    assign issue         = (count != '0);
    assign credit_return = issue;

    always_ff @(posedge clock) begin
        if (req_valid) begin
            q_write[wr_ptr]    <= req_write;
            q_unsigned[wr_ptr] <= req_unsigned;
            q_size[wr_ptr]     <= req_size;
            q_addr[wr_ptr]     <= req_addr;
            q_wdata[wr_ptr]    <= req_wdata;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == QW'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= (rd_ptr == QW'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(req_valid) - CW'(issue);
        end
    end

    // **********************************************************************
    // issue stage
    // **********************************************************************

    addr_t    head_addr;
    byte_en_t lane_en;
    logic     misaligned;
    logic     out_of_range;
    logic     reject;

    assign head_addr = q_addr[rd_ptr];

    store_lane_steer steer_i (
        .size       (q_size[rd_ptr]),
        .addr_low   (head_addr[1:0]),
        .wdata      (q_wdata[rd_ptr]),
        .lane_data  (ram_wdata),
        .lane_en    (lane_en),
        .misaligned (misaligned)
    );

    // word index compared in full so high addresses never alias
    assign out_of_range = (head_addr[31:2] >= 30'(limit));
    assign reject       = misaligned | out_of_range;

    assign ram_addr  = head_addr[AW+1:2];
    assign ram_we    = (issue && q_write[rd_ptr] && !reject) ? lane_en : '0;
    assign err_pulse = issue & reject;

    // **********************************************************************
    // read pipeline and response
    // **********************************************************************

    logic       p_valid;
    logic       p_write;
    logic       p_unsigned;
    logic       p_err;
    access_t    p_size;
    logic [1:0] p_addr_low;
    data_t      load_data;

    always_ff @(posedge clock) begin
        p_write    <= q_write[rd_ptr];
        p_unsigned <= q_unsigned[rd_ptr];
        p_err      <= reject;
        p_size     <= q_size[rd_ptr];
        p_addr_low <= head_addr[1:0];
    end

    load_extract extract_i (
        .size        (p_size),
        .addr_low    (p_addr_low),
        .is_unsigned (p_unsigned),
        .word        (ram_rdata),
        .rdata       (load_data)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            p_valid   <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
            rsp_rdata <= '0;
        end else begin
            p_valid   <= issue;
            rsp_valid <= p_valid;
            rsp_err   <= p_valid & p_err;
            // stores and rejections answer with zero data
            rsp_rdata <= (p_valid && !p_write && !p_err) ? load_data : '0;
        end
    end

endmodule

/* hw/data_mem_top.sv */
`timescale 1ns/10ps

module data_mem_top
    import mem_pkg::*;
#(
    parameter int DEPTH   = 1024,
    parameter int CREDITS = 4
) (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      req_valid,
    input  logic      req_write,
    input  logic      req_unsigned,
    input  access_t   req_size,
    input  addr_t     req_addr,
    input  data_t     req_wdata,
    output logic      credit_return,
    output logic      rsp_valid,
    output logic      rsp_err,
    output data_t     rsp_rdata,
    input  logic      cfg_we,
    input  cfg_addr_t cfg_addr,
    input  data_t     cfg_wdata,
    output data_t     cfg_rdata
);

    localparam int AW = $clog2(DEPTH);

    logic [AW:0]   limit;
    logic          err_pulse;
    logic [AW-1:0] ram_addr;
    byte_en_t      ram_we;
    data_t         ram_wdata;
    data_t         ram_rdata;

    data_mem_ctrl #(
        .DEPTH   (DEPTH),
        .CREDITS (CREDITS)
    ) ctrl_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_unsigned  (req_unsigned),
        .req_size      (req_size),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_err       (rsp_err),
        .rsp_rdata     (rsp_rdata),
        .limit         (limit),
        .err_pulse     (err_pulse),
        .ram_addr      (ram_addr),
        .ram_we        (ram_we),
        .ram_wdata     (ram_wdata),
        .ram_rdata     (ram_rdata)
    );

    mem_cfg_regs #(
        .DEPTH (DEPTH)
    ) cfg_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .err_pulse (err_pulse),
        .limit     (limit)
    );

    // lane 0, bits 7..0
    byte_lane_ram #(.DEPTH(DEPTH)) lane_ram0 (
        .clock (clock),
        .addr  (ram_addr),
        .we    (ram_we[0]),
        .wdata (ram_wdata[7:0]),
        .rdata (ram_rdata[7:0])
    );

    // lane 1, bits 15..8
    byte_lane_ram #(.DEPTH(DEPTH)) lane_ram1 (
        .clock (clock),
        .addr  (ram_addr),
        .we    (ram_we[1]),
        .wdata (ram_wdata[15:8]),
        .rdata (ram_rdata[15:8])
    );

    // lane 2, bits 23..16
    byte_lane_ram #(.DEPTH(DEPTH)) lane_ram2 (
        .clock (clock),
        .addr  (ram_addr),
        .we    (ram_we[2]),
        .wdata (ram_wdata[23:16]),
        .rdata (ram_rdata[23:16])
    );

    // lane 3, bits 31..24
    byte_lane_ram #(.DEPTH(DEPTH)) lane_ram3 (
        .clock (clock),
        .addr  (ram_addr),
        .we    (ram_we[3]),
        .wdata (ram_wdata[31:24]),
        .rdata (ram_rdata[31:24])
    );

endmodule

/* testbench/data_mem_assert.sv */
`timescale 1ns/10ps

module data_mem_assert
    import mem_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input logic                           clock,
    input logic                           rst_n,
    input logic                           req_valid,
    input logic                           credit_return,
    input logic                           rsp_valid,
    input logic                           rsp_err,
    input data_t                          rsp_rdata,
    input logic [$clog2(CREDITS+1)-1:0]   count
);

    // failed assertions so far
    int fail_count = 0;

    logic [$clog2(CREDITS+1)-1:0] queued;

    // requests accepted and not yet issued, seen from the ports
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            queued <= '0;
        end else begin
            queued <= queued + req_valid - credit_return;
        end
    end

    // back-to-back issue needs a request still waiting
    assert property (@(posedge clock) disable iff (!rst_n)
        credit_return ##1 credit_return |-> (queued != '0))
    else begin
        fail_count++;
        $error("credit returned with no request waiting");
    end

    // ram read cycle plus registered response
    assert property (@(posedge clock) disable iff (!rst_n)
        credit_return |-> ##2 rsp_valid)
    else begin
        fail_count++;
        $error("rsp_valid missing two cycles after issue");
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        rsp_err |-> (rsp_rdata == '0))
    else begin
        fail_count++;
        $error("error response with nonzero data");
    end

    // requester holds no credit when the queue is full
    assert property (@(posedge clock) disable iff (!rst_n)
        req_valid |-> (count < CREDITS))
    else begin
        fail_count++;
        $error("request arrived while the queue was full");
    end

endmodule

/* testbench/data_mem_tb.sv */
`timescale 1ns/10ps

module data_mem_tb
    import mem_pkg::*;
();

    localparam int DEPTH   = 1024;
    localparam int CREDITS = 4;
    localparam int TIMEOUT = 200;

    logic      clock;
    logic      rst_n;
    logic      req_valid, req_write, req_unsigned;
    access_t   req_size;
    addr_t     req_addr;
    data_t     req_wdata;
    logic      credit_return, rsp_valid, rsp_err;
    data_t     rsp_rdata;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    data_t     cfg_wdata, cfg_rdata;

    int     credits;
    integer seed;
    int     model_limit;
    logic [7:0] model_mem [4*DEPTH];
    logic   exp_err_q [$];
    data_t  exp_data_q [$];

    data_mem_top #(
        .DEPTH   (DEPTH),
        .CREDITS (CREDITS)
    ) data_mem_top_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_unsigned  (req_unsigned),
        .req_size      (req_size),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_err       (rsp_err),
        .rsp_rdata     (rsp_rdata),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata)
    );

    bind data_mem_ctrl data_mem_assert #(.CREDITS(CREDITS)) assert_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_err       (rsp_err),
        .rsp_rdata     (rsp_rdata),
        .count         (count)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock) begin
        if (rst_n && credit_return) begin
            credits++;
        end
    end

    // **********************************************************************
    // reporting and compare tasks
    // **********************************************************************

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // responses sampled mid-cycle, in request order
    always @(negedge clock) begin
        if (rst_n && rsp_valid) begin
            if (exp_err_q.size() == 0) begin
                stop_on_error("response arrived with no request outstanding");
            end else begin
                check_err("rsp_err", rsp_err, exp_err_q.pop_front());
                check_data("rsp_rdata", rsp_rdata, exp_data_q.pop_front());
            end
        end
    end

    // **********************************************************************
    // reference model and drivers
    // **********************************************************************

    function automatic void model_access(input logic write, input logic uns,
                                         input access_t size, input addr_t addr,
                                         input data_t wdata);
        int    nbytes;
        logic  bad;
        logic  sign;
        data_t value;
        nbytes = (size == access_byte) ? 1 : (size == access_half) ? 2 : 4;
        bad    = ((addr % nbytes) != 0) || (addr[31:2] >= model_limit);
        value  = '0;
        if (!bad && write) begin
            for (int i = 0; i < nbytes; i++) begin
                model_mem[addr[11:0] + i] = wdata[8*i +: 8];
            end
        end else if (!bad) begin
            for (int i = 0; i < nbytes; i++) begin
                value[8*i +: 8] = model_mem[addr[11:0] + i];
            end
            sign = !uns && value[8*nbytes-1];
            for (int i = nbytes; i < 4; i++) begin
                value[8*i +: 8] = {8{sign}};
            end
        end
        exp_err_q.push_back(bad);
        exp_data_q.push_back((bad || write) ? data_t'(0) : value);
    endfunction

    task automatic send_req(input logic write, input logic uns, input access_t size,
                            input addr_t addr, input data_t wdata);
        int waited;
        waited = 0;
        while (credits == 0) begin
            @(posedge clock);
            #2;
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("no credit came back within the timeout");
            end
        end
        model_access(write, uns, size, addr, wdata);
        req_valid    = 1'b1;
        req_write    = write;
        req_unsigned = uns;
        req_size     = size;
        req_addr     = addr;
        req_wdata    = wdata;
        credits--;
        @(posedge clock);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_err_q.size() != 0 || credits != CREDITS) begin
            @(posedge clock);
            #2;
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("responses or credits did not come back within the timeout");
            end
        end
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input data_t data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clock);
        #2;
        cfg_we = 1'b0;
        if (addr == CFG_LIMIT) begin
            model_limit = data;
        end
    endtask

    task automatic cfg_check(input cfg_addr_t addr, input data_t exp);
        cfg_addr = addr;
        #1;
        check_data((addr == CFG_LIMIT) ? "cfg_rdata limit" : "cfg_rdata err_count",
                   cfg_rdata, exp);
        @(posedge clock);
        #2;
    endtask

    // **********************************************************************
    // directed tests
    // **********************************************************************

    task automatic test_word_access();
        addr_t addrs [5] = '{32'h0, 32'h4, 32'h40, 32'h3fc, 32'hffc};
        foreach (addrs[i]) begin
            send_req(1'b1, 1'b0, access_word, addrs[i], 32'h1357_9bdf ^ (addrs[i] << 4));
        end
        foreach (addrs[i]) begin
            send_req(1'b0, 1'b0, access_word, addrs[i], '0);
        end
        wait_drain();
    endtask

    task automatic test_sub_word();
        // one byte store into each lane, upper data bits are junk
        for (int lane = 0; lane < 4; lane++) begin
            send_req(1'b1, 1'b0, access_word, 32'h200 + 4*lane, 32'h8899_aabb ^ lane);
            send_req(1'b1, 1'b0, access_byte, 32'h200 + 5*lane, 32'hcafe_0080 + 17*lane);
        end
        send_req(1'b1, 1'b0, access_word, 32'h210, 32'h0123_4567);
        send_req(1'b1, 1'b0, access_word, 32'h214, 32'h7654_3210);
        send_req(1'b1, 1'b0, access_half, 32'h210, 32'hffff_9a5c);
        send_req(1'b1, 1'b0, access_half, 32'h216, 32'h0000_81e7);
        for (int a = 32'h200; a < 32'h218; a++) begin
            send_req(1'b0, 1'b0, access_byte, a, '0);
            send_req(1'b0, 1'b1, access_byte, a, '0);
            if (a % 2 == 0) begin
                send_req(1'b0, 1'b0, access_half, a, '0);
                send_req(1'b0, 1'b1, access_half, a, '0);
            end
            if (a % 4 == 0) begin
                send_req(1'b0, 1'b0, access_word, a, '0);
            end
        end
        wait_drain();
    endtask

    task automatic test_misaligned();
        access_t sizes [6] = '{access_half, access_half, access_word,
                               access_word, access_word, access_half};
        int      offs  [6] = '{1, 3, 1, 2, 3, 1};
        cfg_write(CFG_ERR_COUNT, '0);
        send_req(1'b1, 1'b0, access_word, 32'h300, 32'hcafe_f00d);
        wait_drain();
        for (int k = 0; k < 6; k++) begin
            send_req(k[0], 1'b0, sizes[k], 32'h300 + offs[k], 32'hffff_ffff);
            wait_drain();
            cfg_check(CFG_ERR_COUNT, k + 1);
        end
        send_req(1'b0, 1'b0, access_word, 32'h300, '0);
        wait_drain();
    endtask

    task automatic test_limit();
        cfg_write(CFG_LIMIT, 32'd16);
        cfg_check(CFG_LIMIT, 32'd16);
        cfg_write(CFG_ERR_COUNT, '0);
        send_req(1'b1, 1'b0, access_word, 15*4, 32'h0f0f_5a5a);
        send_req(1'b1, 1'b0, access_word, 16*4, 32'h0000_0001);
        send_req(1'b0, 1'b0, access_byte, 16*4 + 3, '0);
        send_req(1'b0, 1'b0, access_word, 40*4, '0);
        send_req(1'b0, 1'b1, access_half, 15*4 + 2, '0);
        send_req(1'b0, 1'b0, access_word, 15*4, '0);
        wait_drain();
        cfg_check(CFG_ERR_COUNT, 32'd3);
        cfg_write(CFG_ERR_COUNT, 32'h1234);
        cfg_check(CFG_ERR_COUNT, '0);
        cfg_write(CFG_LIMIT, DEPTH);
        cfg_check(CFG_LIMIT, DEPTH);
    endtask

    task automatic test_random();
        int      r;
        logic    wr;
        logic    uns;
        access_t sz;
        addr_t   a;
        // known contents in the 64 words the stream touches
        for (int w = 0; w < 64; w++) begin
            send_req(1'b1, 1'b0, access_word, w*4, (32'h9e37_79b9 * (w + 1)) ^ (w*4));
        end
        for (int n = 0; n < 40; n++) begin
            r   = $random(seed);
            wr  = r[0];
            uns = r[1];
            sz  = access_t'($unsigned($random(seed)) % 3);
            a   = $random(seed) & 32'hff;
            send_req(wr, uns, sz, a, $random(seed));
        end
        wait_drain();
    endtask

    initial begin
        seed         = 99;
        credits      = CREDITS;
        model_limit  = DEPTH;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_unsigned = 1'b0;
        req_size     = access_word;
        req_addr     = '0;
        req_wdata    = '0;
        cfg_we       = 1'b0;
        cfg_addr     = CFG_LIMIT;
        cfg_wdata    = '0;
        repeat (8) @(posedge clock);
        #2;
        rst_n = 1'b1;
        check_err("credit_return", credit_return, 1'b0);
        check_err("rsp_valid", rsp_valid, 1'b0);
        cfg_check(CFG_LIMIT, DEPTH);

        test_word_access();
        test_sub_word();
        test_misaligned();
        test_limit();
        test_random();

        if (data_mem_top_i.ctrl_i.assert_i.fail_count != 0) begin
            stop_on_error("concurrent assertions failed during the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* build.f */
hw/mem_pkg.sv
hw/byte_lane_ram.sv
hw/store_lane_steer.sv
hw/load_extract.sv
hw/mem_cfg_regs.sv
hw/data_mem_ctrl.sv
hw/data_mem_top.sv
testbench/data_mem_assert.sv
testbench/data_mem_tb.sv
